// ==== rtl/sigma_tile_pkg.sv ====
/*
 * sigma tile shared definitions
 * bus widths, address decode, RAM size, SFR map, tile id and state types
 */

package sigma_tile_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = 4;

    // address decode
    localparam int XIF_BITSEL = 31;
    localparam int SFR_BITSEL = 20;

    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;

    // interrupts
    localparam int IRQ_NUM_POW    = 4;
    localparam int IRQ_NUM        = 2**IRQ_NUM_POW;
    localparam int IRQ_TIMER_LINE = 1;

    localparam logic [DATA_W-1:0] TILE_ID = 32'h0000_0007;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOCAL,
        ST_LOCAL_RESP,
        ST_XIF,
        ST_DONE
    } ctrl_state_e;

    // word offsets inside the SFR block
    typedef enum logic [2:0] {
        SFR_ID           = 3'd0,
        SFR_CORE_RST     = 3'd1,
        SFR_IRQ_EN       = 3'd2,
        SFR_SGI          = 3'd3,
        SFR_TIMER_PERIOD = 3'd4
    } sfr_reg_e;

    typedef enum logic [1:0] {
        TGT_DMEM,
        TGT_SFR,
        TGT_XIF
    } bus_target_e;

endpackage

// ==== rtl/tile_bus_if.sv ====
/*
 * tile internal bus
 * one-cycle request, one-cycle acknowledge with read data on the next cycle
 */

interface tile_bus_if;

    logic                              req;
    logic                              we;
    logic [sigma_tile_pkg::ADDR_W-1:0] addr;
    logic [sigma_tile_pkg::BE_W-1:0]   be;
    logic [sigma_tile_pkg::DATA_W-1:0] wdata;
    logic                              ack;
    logic [sigma_tile_pkg::DATA_W-1:0] rdata;

    modport master (
        output req, we, addr, be, wdata,
        input  ack, rdata
    );

    modport slave (
        input  req, we, addr, be, wdata,
        output ack, rdata
    );

endinterface

// ==== rtl/tile_dmem.sv ====
/*
 * tile data RAM
 * single port, byte write enables, acknowledge one cycle after request
 */

module tile_dmem
(
    input  logic      clk_i
    , tile_bus_if.slave bus_i
);

    logic [sigma_tile_pkg::DATA_W-1:0] mem [sigma_tile_pkg::RAM_WORDS];
    logic [sigma_tile_pkg::RAM_AW-1:0] widx;

    // word index only, upper address bits wrap
    assign widx = bus_i.addr[sigma_tile_pkg::RAM_AW+1:2];

    always_ff @(posedge clk_i)
    begin
        bus_i.ack <= bus_i.req;
        if (bus_i.req)
        begin
            // read returns old contents on a write
            bus_i.rdata <= mem[widx];
            if (bus_i.we)
            begin
                for (int b = 0; b < sigma_tile_pkg::BE_W; b++)
                begin
                    if (bus_i.be[b])
                        mem[widx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== rtl/tile_sfr.sv ====
/*
 * special function registers
 * tile id, core reset, interrupt enable mask, software interrupt
 * and a periodic timer
 */

module tile_sfr
(
    input  logic                                     clk_i
    , input  logic                                   rst_n_i
    , tile_bus_if.slave                              bus_i
    , output logic                                   core_reset_o
    , output logic [sigma_tile_pkg::IRQ_NUM-1:0]     irq_en_o
    , output logic                                   timer_irq_o
    , output logic                                   sgi_req_o
    , output logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] sgi_code_o
);

    sigma_tile_pkg::sfr_reg_e          offset;
    logic                              wr;
    logic [sigma_tile_pkg::DATA_W-1:0] wmask;
    logic [sigma_tile_pkg::DATA_W-1:0] irq_en_word;
    logic [sigma_tile_pkg::DATA_W-1:0] period;
    logic [sigma_tile_pkg::DATA_W-1:0] count;
    logic [sigma_tile_pkg::DATA_W-1:0] rd_word;

    assign offset = sigma_tile_pkg::sfr_reg_e'(bus_i.addr[4:2]);
    assign wr     = bus_i.req && bus_i.we;

    // byte enables widened to a bit mask
    always_comb
    begin
        for (int b = 0; b < sigma_tile_pkg::BE_W; b++)
            wmask[b*8 +: 8] = {8{bus_i.be[b]}};
    end

    assign irq_en_word = {{(sigma_tile_pkg::DATA_W-sigma_tile_pkg::IRQ_NUM){1'b0}}, irq_en_o};

    always_comb
    begin
        case (offset)
            sigma_tile_pkg::SFR_ID:           rd_word = sigma_tile_pkg::TILE_ID;
            sigma_tile_pkg::SFR_CORE_RST:     rd_word = {31'd0, core_reset_o};
            sigma_tile_pkg::SFR_IRQ_EN:       rd_word = irq_en_word;
            sigma_tile_pkg::SFR_TIMER_PERIOD: rd_word = period;
            // SGI and unused offsets read zero
            default:                          rd_word = '0;
        endcase
    end

    //////////////////////////////
    // register writes and bus response
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            bus_i.ack    <= 1'b0;
            core_reset_o <= 1'b0;
            irq_en_o     <= '0;
            period       <= '0;
            sgi_req_o    <= 1'b0;
        end
        else
        begin
            bus_i.ack <= bus_i.req;
            sgi_req_o <= wr && bus_i.be[0] && (offset == sigma_tile_pkg::SFR_SGI);
            if (wr && bus_i.be[0] && offset == sigma_tile_pkg::SFR_CORE_RST)
                core_reset_o <= bus_i.wdata[0];
            if (wr && offset == sigma_tile_pkg::SFR_IRQ_EN)
                irq_en_o <= (irq_en_o & ~wmask[sigma_tile_pkg::IRQ_NUM-1:0])
                            | (bus_i.wdata[sigma_tile_pkg::IRQ_NUM-1:0]
                               & wmask[sigma_tile_pkg::IRQ_NUM-1:0]);
            if (wr && offset == sigma_tile_pkg::SFR_TIMER_PERIOD)
                period <= (period & ~wmask) | (bus_i.wdata & wmask);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (bus_i.req)
            bus_i.rdata <= rd_word;
        if (wr && offset == sigma_tile_pkg::SFR_SGI)
            sgi_code_o <= bus_i.wdata[sigma_tile_pkg::IRQ_NUM_POW-1:0];
    end

    //////////////////////////////
    // timer stops while the period is zero
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            count       <= '0;
            timer_irq_o <= 1'b0;
        end
        else
        begin
            timer_irq_o <= 1'b0;
            if (period == '0)
                count <= '0;
            else if (count >= period - 1'b1)
            begin
                count       <= '0;
                timer_irq_o <= 1'b1;
            end
            else
                count <= count + 1'b1;
        end
    end

endmodule

// ==== rtl/tile_irq_adapter.sv ====
/*
 * interrupt adapter
 * latches enabled lines and SGIs, presents one code with req/ack
 */

module tile_irq_adapter
(
    input  logic                                     clk_i
    , input  logic                                   rst_n_i
    , input  logic                                   core_reset_i
    , input  logic [sigma_tile_pkg::IRQ_NUM-1:0]     irq_i
    , input  logic [sigma_tile_pkg::IRQ_NUM-1:0]     irq_en_i
    , input  logic                                   timer_irq_i
    , input  logic                                   sgi_req_i
    , input  logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] sgi_code_i
    , input  logic                                   irq_ack_i
    , output logic                                   irq_req_o
    , output logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] irq_code_o
);

    logic [sigma_tile_pkg::IRQ_NUM-1:0]     lines;
    logic [sigma_tile_pkg::IRQ_NUM-1:0]     pending;
    logic [sigma_tile_pkg::IRQ_NUM-1:0]     clr_mask;
    logic                                   sgi_pend;
    logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] sgi_code_q;
    logic                                   pres_sgi;
    logic                                   ack_ok;
    logic                                   sel_valid;
    logic                                   sel_sgi;
    logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] sel_code;

    assign lines = (irq_i | ({{(sigma_tile_pkg::IRQ_NUM-1){1'b0}}, timer_irq_i}
                    << sigma_tile_pkg::IRQ_TIMER_LINE)) & irq_en_i;
    assign ack_ok = irq_req_o && irq_ack_i;

    // the presented line is dropped on ack, SGIs are handled apart
    always_comb
    begin
        clr_mask = '0;
        if (ack_ok && !pres_sgi)
            clr_mask[irq_code_o] = 1'b1;
    end

    // SGI first, then the lowest pending line
    always_comb
    begin
        sel_valid = sgi_pend || (pending != '0);
        sel_sgi   = sgi_pend;
        sel_code  = sgi_code_q;
        if (!sgi_pend)
        begin
            for (int i = sigma_tile_pkg::IRQ_NUM - 1; i >= 0; i--)
            begin
                if (pending[i])
                    sel_code = sigma_tile_pkg::IRQ_NUM_POW'(i);
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i || core_reset_i)
        begin
            pending   <= '0;
            sgi_pend  <= 1'b0;
            pres_sgi  <= 1'b0;
            irq_req_o <= 1'b0;
        end
        else
        begin
            // a line raised in the ack cycle stays pending
            pending <= (pending & ~clr_mask) | lines;
            if (sgi_req_i)
                sgi_pend <= 1'b1;
            else if (ack_ok && pres_sgi)
                sgi_pend <= 1'b0;

            if (ack_ok)
                irq_req_o <= 1'b0;
            else
            begin
                irq_req_o <= sel_valid;
                pres_sgi  <= sel_sgi;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (sgi_req_i)
            sgi_code_q <= sgi_code_i;
        if (!ack_ok)
            irq_code_o <= sel_code;
    end

endmodule

// ==== rtl/tile_bus_ctrl.sv ====
/*
 * tile bus controller
 * takes Wishbone host cycles, decodes the target and runs the transfer
 * on the RAM, the SFR block or the expansion master port
 */

module tile_bus_ctrl
(
    input  logic                                clk_i
    , input  logic                              rst_n_i

    , input  logic                              wb_cyc_i
    , input  logic                              wb_stb_i
    , input  logic                              wb_we_i
    , input  logic [sigma_tile_pkg::ADDR_W-1:0] wb_adr_i
    , input  logic [sigma_tile_pkg::BE_W-1:0]   wb_sel_i
    , input  logic [sigma_tile_pkg::DATA_W-1:0] wb_dat_i
    , output logic [sigma_tile_pkg::DATA_W-1:0] wb_dat_o
    , output logic                              wb_ack_o

    , output logic                              xif_cyc_o
    , output logic                              xif_stb_o
    , output logic                              xif_we_o
    , output logic [sigma_tile_pkg::ADDR_W-1:0] xif_adr_o
    , output logic [sigma_tile_pkg::BE_W-1:0]   xif_sel_o
    , output logic [sigma_tile_pkg::DATA_W-1:0] xif_dat_o
    , input  logic [sigma_tile_pkg::DATA_W-1:0] xif_dat_i
    , input  logic                              xif_ack_i

    , tile_bus_if.master                        dmem_o
    , tile_bus_if.master                        sfr_o
);

    sigma_tile_pkg::ctrl_state_e state;
    sigma_tile_pkg::bus_target_e target;
    sigma_tile_pkg::bus_target_e host_tgt;

    logic                              req_q;
    logic                              we_q;
    logic [sigma_tile_pkg::ADDR_W-1:0] adr_q;
    logic [sigma_tile_pkg::BE_W-1:0]   sel_q;
    logic [sigma_tile_pkg::DATA_W-1:0] wdata_q;
    logic [sigma_tile_pkg::DATA_W-1:0] rdata_q;
    logic                              local_ack;
    logic [sigma_tile_pkg::DATA_W-1:0] local_rdata;

    // expansion bit wins over the SFR bit
    always_comb
    begin
        if (wb_adr_i[sigma_tile_pkg::XIF_BITSEL])
            host_tgt = sigma_tile_pkg::TGT_XIF;
        else if (wb_adr_i[sigma_tile_pkg::SFR_BITSEL])
            host_tgt = sigma_tile_pkg::TGT_SFR;
        else
            host_tgt = sigma_tile_pkg::TGT_DMEM;
    end

    //////////////////////////////
    // state machine
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state <= sigma_tile_pkg::ST_IDLE;
            req_q <= 1'b0;
        end
        else
        begin
            req_q <= 1'b0;
            case (state)
                sigma_tile_pkg::ST_IDLE:
                    if (wb_cyc_i && wb_stb_i)
                    begin
                        if (host_tgt == sigma_tile_pkg::TGT_XIF)
                            state <= sigma_tile_pkg::ST_XIF;
                        else
                            state <= sigma_tile_pkg::ST_LOCAL;
                    end
                sigma_tile_pkg::ST_LOCAL:
                begin
                    req_q <= 1'b1;
                    state <= sigma_tile_pkg::ST_LOCAL_RESP;
                end
                sigma_tile_pkg::ST_LOCAL_RESP:
                    if (local_ack)
                        state <= sigma_tile_pkg::ST_DONE;
                sigma_tile_pkg::ST_XIF:
                    if (xif_ack_i)
                        state <= sigma_tile_pkg::ST_DONE;
                default:
                    state <= sigma_tile_pkg::ST_IDLE;
            endcase
        end
    end

    // request fields are held by the host, capture them while idle
    always_ff @(posedge clk_i)
    begin
        if (state == sigma_tile_pkg::ST_IDLE)
        begin
            target  <= host_tgt;
            we_q    <= wb_we_i;
            adr_q   <= wb_adr_i;
            sel_q   <= wb_sel_i;
            wdata_q <= wb_dat_i;
        end
        if (state == sigma_tile_pkg::ST_LOCAL_RESP && local_ack)
            rdata_q <= local_rdata;
        if (state == sigma_tile_pkg::ST_XIF && xif_ack_i)
            rdata_q <= xif_dat_i;
    end

    //////////////////////////////
    // local targets
    assign local_ack   = (target == sigma_tile_pkg::TGT_SFR) ? sfr_o.ack : dmem_o.ack;
    assign local_rdata = (target == sigma_tile_pkg::TGT_SFR) ? sfr_o.rdata : dmem_o.rdata;

    assign dmem_o.req   = req_q && (target == sigma_tile_pkg::TGT_DMEM);
    assign dmem_o.we    = we_q;
    assign dmem_o.addr  = adr_q;
    assign dmem_o.be    = sel_q;
    assign dmem_o.wdata = wdata_q;

    assign sfr_o.req    = req_q && (target == sigma_tile_pkg::TGT_SFR);
    assign sfr_o.we     = we_q;
    assign sfr_o.addr   = adr_q;
    assign sfr_o.be     = sel_q;
    assign sfr_o.wdata  = wdata_q;

    // expansion master, cycle held until the slave acks
    assign xif_cyc_o = (state == sigma_tile_pkg::ST_XIF);
    assign xif_stb_o = (state == sigma_tile_pkg::ST_XIF);
    assign xif_we_o  = we_q;
    assign xif_adr_o = adr_q;
    assign xif_sel_o = sel_q;
    assign xif_dat_o = wdata_q;

    assign wb_ack_o = (state == sigma_tile_pkg::ST_DONE);
    assign wb_dat_o = rdata_q;

endmodule

// ==== rtl/sigma_tile.sv ====
/*
 * sigma tile top level
 * Wishbone host port decoded to data RAM, SFR block and expansion port,
 * plus the interrupt adapter that stands in front of the core
 */

module sigma_tile
(
    input  logic                                   clk_i
    , input  logic                                 rst_n_i

    // host port
    , input  logic                                 wb_cyc_i
    , input  logic                                 wb_stb_i
    , input  logic                                 wb_we_i
    , input  logic [sigma_tile_pkg::ADDR_W-1:0]    wb_adr_i
    , input  logic [sigma_tile_pkg::BE_W-1:0]      wb_sel_i
    , input  logic [sigma_tile_pkg::DATA_W-1:0]    wb_dat_i
    , output logic [sigma_tile_pkg::DATA_W-1:0]    wb_dat_o
    , output logic                                 wb_ack_o

    // expansion port
    , output logic                                 xif_cyc_o
    , output logic                                 xif_stb_o
    , output logic                                 xif_we_o
    , output logic [sigma_tile_pkg::ADDR_W-1:0]    xif_adr_o
    , output logic [sigma_tile_pkg::BE_W-1:0]      xif_sel_o
    , output logic [sigma_tile_pkg::DATA_W-1:0]    xif_dat_o
    , input  logic [sigma_tile_pkg::DATA_W-1:0]    xif_dat_i
    , input  logic                                 xif_ack_i

    // interrupts
    , input  logic [sigma_tile_pkg::IRQ_NUM-1:0]   irq_i
    , input  logic                                 irq_ack_i
    , output logic                                 irq_req_o
    , output logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] irq_code_o
    , output logic                                 core_reset_o
);

    tile_bus_if dmem_if();
    tile_bus_if sfr_if();

    logic [sigma_tile_pkg::IRQ_NUM-1:0]     irq_en;
    logic                                   timer_irq;
    logic                                   sgi_req;
    logic [sigma_tile_pkg::IRQ_NUM_POW-1:0] sgi_code;

    tile_bus_ctrl bus_ctrl (
        .clk_i        (clk_i)
        , .rst_n_i    (rst_n_i)
        , .wb_cyc_i   (wb_cyc_i)
        , .wb_stb_i   (wb_stb_i)
        , .wb_we_i    (wb_we_i)
        , .wb_adr_i   (wb_adr_i)
        , .wb_sel_i   (wb_sel_i)
        , .wb_dat_i   (wb_dat_i)
        , .wb_dat_o   (wb_dat_o)
        , .wb_ack_o   (wb_ack_o)
        , .xif_cyc_o  (xif_cyc_o)
        , .xif_stb_o  (xif_stb_o)
        , .xif_we_o   (xif_we_o)
        , .xif_adr_o  (xif_adr_o)
        , .xif_sel_o  (xif_sel_o)
        , .xif_dat_o  (xif_dat_o)
        , .xif_dat_i  (xif_dat_i)
        , .xif_ack_i  (xif_ack_i)
        , .dmem_o     (dmem_if)
        , .sfr_o      (sfr_if)
    );

    tile_dmem dmem (
        .clk_i        (clk_i)
        , .bus_i      (dmem_if)
    );

    tile_sfr sfr (
        .clk_i          (clk_i)
        , .rst_n_i      (rst_n_i)
        , .bus_i        (sfr_if)
        , .core_reset_o (core_reset_o)
        , .irq_en_o     (irq_en)
        , .timer_irq_o  (timer_irq)
        , .sgi_req_o    (sgi_req)
        , .sgi_code_o   (sgi_code)
    );

    // adapter is held clear while the core is in reset
    tile_irq_adapter irq_adapter (
        .clk_i          (clk_i)
        , .rst_n_i      (rst_n_i)
        , .core_reset_i (core_reset_o)
        , .irq_i        (irq_i)
        , .irq_en_i     (irq_en)
        , .timer_irq_i  (timer_irq)
        , .sgi_req_i    (sgi_req)
        , .sgi_code_i   (sgi_code)
        , .irq_ack_i    (irq_ack_i)
        , .irq_req_o    (irq_req_o)
        , .irq_code_o   (irq_code_o)
    );

endmodule

// ==== verification/sigma_tile_tb.sv ====
/*
 * sigma tile testbench
 * host Wishbone master, expansion slave model with random wait states,
 * protocol assertions and interrupt sequences
 */

module sigma_tile_tb;

    localparam int CLK_PERIOD = 8;
    // about five times the cycles the tests need with the timer run
    localparam int MAX_CYCLES = 2500;
    localparam logic [31:0] SFR_BASE = 32'h1 << sigma_tile_pkg::SFR_BITSEL;
    localparam logic [31:0] XIF_BASE = 32'h1 << sigma_tile_pkg::XIF_BITSEL;
    localparam logic [31:0] XIF_MIX  = 32'hA5A5_0000;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        xif_cyc_o;
    logic        xif_stb_o;
    logic        xif_we_o;
    logic [31:0] xif_adr_o;
    logic [3:0]  xif_sel_o;
    logic [31:0] xif_dat_o;
    logic [31:0] xif_dat_i = '0;
    logic        xif_ack_i = 1'b0;
    logic [15:0] irq_i;
    logic        irq_ack_i;
    logic        irq_req_o;
    logic [3:0]  irq_code_o;
    logic        core_reset_o;

    int errors = 0;
    int err_mark = 0;
    int n_tests = 0;
    int n_failed = 0;
    int cycle_cnt = 0;
    int last_latency;

    // expansion slave model state
    integer      seed = 32'h81f9bc21;
    int          wait_left;
    int          last_wait;
    logic        xif_busy;
    logic        last_we;
    logic [31:0] last_adr;
    logic [31:0] last_wr_dat;
    logic [3:0]  last_sel;

    sigma_tile DUT (
        .clk_i          (clk_i)
        , .rst_n_i      (rst_n_i)
        , .wb_cyc_i     (wb_cyc_i)
        , .wb_stb_i     (wb_stb_i)
        , .wb_we_i      (wb_we_i)
        , .wb_adr_i     (wb_adr_i)
        , .wb_sel_i     (wb_sel_i)
        , .wb_dat_i     (wb_dat_i)
        , .wb_dat_o     (wb_dat_o)
        , .wb_ack_o     (wb_ack_o)
        , .xif_cyc_o    (xif_cyc_o)
        , .xif_stb_o    (xif_stb_o)
        , .xif_we_o     (xif_we_o)
        , .xif_adr_o    (xif_adr_o)
        , .xif_sel_o    (xif_sel_o)
        , .xif_dat_o    (xif_dat_o)
        , .xif_dat_i    (xif_dat_i)
        , .xif_ack_i    (xif_ack_i)
        , .irq_i        (irq_i)
        , .irq_ack_i    (irq_ack_i)
        , .irq_req_o    (irq_req_o)
        , .irq_code_o   (irq_code_o)
        , .core_reset_o (core_reset_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i)
        cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////
    // expansion slave model with a random wait of 0 to 5 cycles
    always @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            xif_ack_i <= 1'b0;
            xif_busy = 1'b0;
        end
        else
        begin
            xif_ack_i <= 1'b0;
            if (xif_cyc_o && xif_stb_o && !xif_ack_i)
            begin
                if (!xif_busy)
                begin
                    xif_busy = 1'b1;
                    wait_left = $unsigned($random(seed)) % 6;
                    last_wait = wait_left;
                    last_adr = xif_adr_o;
                    last_sel = xif_sel_o;
                    last_we = xif_we_o;
                    if (xif_we_o)
                        last_wr_dat = xif_dat_o;
                end
                if (wait_left == 0)
                begin
                    xif_ack_i <= 1'b1;
                    xif_dat_i <= xif_adr_o ^ XIF_MIX;
                    xif_busy = 1'b0;
                end
                else
                    wait_left = wait_left - 1;
            end
        end
    end

    //////////////////////////////
    // protocol assertions
    assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_ack_o |=> !wb_ack_o)
    else
    begin
        errors++;
        $display("host ack stayed high for more than one cycle at time %0t", $time);
    end

    // ack rises at the third edge and shows in the sampled values one edge later
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(wb_stb_i) && !wb_adr_i[sigma_tile_pkg::XIF_BITSEL] |-> ##4 wb_ack_o)
    else
    begin
        errors++;
        $display("local access not acknowledged 3 cycles after request at time %0t", $time);
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        xif_stb_o && !xif_ack_i |=> xif_stb_o && $stable(xif_adr_o) && $stable(xif_dat_o))
    else
    begin
        errors++;
        $display("expansion strobe or fields changed before ack at time %0t", $time);
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        xif_stb_o && xif_ack_i |=> wb_ack_o)
    else
    begin
        errors++;
        $display("host ack did not follow expansion ack at time %0t", $time);
    end

    // line 3 is never enabled
    assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_req_o |-> irq_code_o != 4'd3)
    else
    begin
        errors++;
        $display("masked line 3 was presented at time %0t", $time);
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_req_o && irq_ack_i |=> !irq_req_o)
    else
    begin
        errors++;
        $display("interrupt request did not drop after ack at time %0t", $time);
    end

    //////////////////////////////
    // helpers
    function automatic logic [31:0] sfr_addr(input sigma_tile_pkg::sfr_reg_e r);
        return SFR_BASE | {27'd0, r, 2'b00};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_sel_i <= sel;
        wb_dat_i <= wdat;
        @(posedge clk_i);
        last_latency = 0;
        while (!wb_ack_o)
        begin
            @(posedge clk_i);
            last_latency++;
        end
        rdat = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [31:0] unused;
        bus_access(1'b1, adr, sel, dat, unused);
    endtask

    task automatic read_word(input logic [31:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, 4'hf, 32'h0, dat);
    endtask

    task automatic pulse_irq(input logic [15:0] lines);
        @(posedge clk_i);
        irq_i <= lines;
        @(posedge clk_i);
        irq_i <= '0;
    endtask

    task automatic wait_irq_req();
        @(posedge clk_i);
        while (!irq_req_o)
            @(posedge clk_i);
    endtask

    // acknowledge raised at the edge where the request was seen
    task automatic ack_irq();
        irq_ack_i <= 1'b1;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors == err_mark)
            $display("test %0d %s: passed", n_tests, name);
        else
        begin
            n_failed++;
            $display("test %0d %s: failed with %0d errors", n_tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    //////////////////////////////
    // test sequence
    initial
    begin
        logic [31:0] rd;
        logic [31:0] adr;
        int          last_rise;

        rst_n_i   <= 1'b0;
        wb_cyc_i  <= 1'b0;
        wb_stb_i  <= 1'b0;
        wb_we_i   <= 1'b0;
        wb_adr_i  <= '0;
        wb_sel_i  <= '0;
        wb_dat_i  <= '0;
        irq_i     <= '0;
        irq_ack_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        check_value(wb_ack_o, 0, "wb_ack_o after reset");
        check_value(xif_cyc_o, 0, "xif_cyc_o after reset");
        check_value(irq_req_o, 0, "irq_req_o after reset");
        check_value(core_reset_o, 0, "core_reset_o after reset");
        end_test("reset state");

        write_word(32'h0000_0010, 32'h1122_3344, 4'hf);
        write_word(32'h0000_0014, 32'hcafe_f00d, 4'hf);
        read_word(32'h0000_0010, rd);
        check_value(rd, 32'h1122_3344, "RAM word 4");
        read_word(32'h0000_0014, rd);
        check_value(rd, 32'hcafe_f00d, "RAM word 5");
        write_word(32'h0000_0010, 32'haabb_ccdd, 4'b0101);
        read_word(32'h0000_0010, rd);
        check_value(rd, 32'h11bb_33dd, "RAM partial write");
        // word index 1024 wraps onto index 0
        write_word(32'h0000_1000, 32'h5a5a_0f0f, 4'hf);
        read_word(32'h0000_0000, rd);
        check_value(rd, 32'h5a5a_0f0f, "RAM address wrap");
        end_test("data RAM");

        write_word(XIF_BASE | 32'h40, 32'h1234_5678, 4'b0011);
        check_value(last_adr, XIF_BASE | 32'h40, "expansion write address");
        check_value(last_wr_dat, 32'h1234_5678, "expansion write data");
        check_value(last_sel, 4'b0011, "expansion write select");
        check_value(last_we, 1'b1, "expansion write enable");
        check_value(last_latency, last_wait + 3, "expansion write latency");
        for (int i = 0; i < 4; i++)
        begin
            adr = XIF_BASE | (32'h100 + i * 32'h24);
            read_word(adr, rd);
            check_value(rd, adr ^ XIF_MIX, "expansion read data");
            check_value(last_adr, adr, "expansion read address");
            check_value(last_sel, 4'hf, "expansion read select");
            check_value(last_we, 1'b0, "expansion read enable");
            check_value(last_latency, last_wait + 3, "expansion read latency");
        end
        end_test("expansion pass-through");

        read_word(sfr_addr(sigma_tile_pkg::SFR_ID), rd);
        check_value(rd, sigma_tile_pkg::TILE_ID, "tile id");
        write_word(sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 32'h0000_0220, 4'hf);
        read_word(sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), rd);
        check_value(rd, 32'h0000_0220, "irq enable readback");
        write_word(sfr_addr(sigma_tile_pkg::SFR_CORE_RST), 32'h1, 4'hf);
        check_value(core_reset_o, 1'b1, "core reset set");
        write_word(sfr_addr(sigma_tile_pkg::SFR_CORE_RST), 32'h0, 4'hf);
        check_value(core_reset_o, 1'b0, "core reset cleared");
        end_test("SFR access");

        // only lines 5 and 9 enabled
        write_word(sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 32'h0000_0220, 4'hf);
        pulse_irq(16'h0228);
        wait_irq_req();
        check_value(irq_code_o, 4'd5, "first line code");
        ack_irq();
        wait_irq_req();
        check_value(irq_code_o, 4'd9, "second line code");
        ack_irq();
        repeat (6) @(posedge clk_i);
        check_value(irq_req_o, 1'b0, "request after both lines served");
        pulse_irq(16'h0020);
        wait_irq_req();
        write_word(sfr_addr(sigma_tile_pkg::SFR_CORE_RST), 32'h1, 4'hf);
        check_value(core_reset_o, 1'b1, "core reset with pending line");
        check_value(irq_req_o, 1'b0, "request under core reset");
        write_word(sfr_addr(sigma_tile_pkg::SFR_CORE_RST), 32'h0, 4'hf);
        repeat (3) @(posedge clk_i);
        check_value(irq_req_o, 1'b0, "request after core reset release");
        end_test("masked line interrupts");

        pulse_irq(16'h0200);
        wait_irq_req();
        check_value(irq_code_o, 4'd9, "line 9 pending");
        write_word(sfr_addr(sigma_tile_pkg::SFR_SGI), 32'd12, 4'hf);
        wait_irq_req();
        check_value(irq_code_o, 4'd12, "SGI ahead of line 9");
        ack_irq();
        wait_irq_req();
        check_value(irq_code_o, 4'd9, "line 9 after SGI");
        ack_irq();
        write_word(sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 32'h0000_0002, 4'hf);
        write_word(sfr_addr(sigma_tile_pkg::SFR_TIMER_PERIOD), 32'd20, 4'hf);
        last_rise = 0;
        for (int k = 0; k < 3; k++)
        begin
            wait_irq_req();
            check_value(irq_code_o, 4'd1, "timer line code");
            if (k > 0)
                check_value(cycle_cnt - last_rise, 20, "timer request spacing");
            last_rise = cycle_cnt;
            ack_irq();
        end
        write_word(sfr_addr(sigma_tile_pkg::SFR_TIMER_PERIOD), 32'd0, 4'hf);
        write_word(sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 32'd0, 4'hf);
        end_test("SGI and timer");

        $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog
    initial
    begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== sigma_tile.f ====
rtl/sigma_tile_pkg.sv
rtl/tile_bus_if.sv
rtl/tile_dmem.sv
rtl/tile_sfr.sv
rtl/tile_irq_adapter.sv
rtl/tile_bus_ctrl.sv
rtl/sigma_tile.sv
verification/sigma_tile_tb.sv
